/* Bender.yml */
package:
  name: copy_engine

sources:
  - logic/ccipPkg.sv
  - logic/creditFifo.sv
  - logic/copyControl.sv
  - logic/lineWriter.sv
  - logic/txnTracer.sv
  - logic/copyEngineTop.sv
  - target: test
    files:
      - tb/hostMemModel.sv
      - tb/copyEngineTb.sv

/* filelist.f */
logic/ccipPkg.sv
logic/creditFifo.sv
logic/copyControl.sv
logic/lineWriter.sv
logic/txnTracer.sv
logic/copyEngineTop.sv
tb/hostMemModel.sv
tb/copyEngineTb.sv

/* logic/ccipPkg.sv */
// Copy engine shared widths, channel codes, register map and header structs
`default_nettype none

package ccipPkg;

   //////////////////////////////////////////////////////////////////////
   // Widths
   //////////////////////////////////////////////////////////////////////
   localparam int LINE_W      = 64;
   localparam int ADDR_W      = 32;
   localparam int MDATA_W     = 16;
   localparam int TS_W        = 32;
   localparam int MMIO_W      = 64;
   localparam int MMIO_IDX_W  = 16;
   localparam int TID_W       = 9;
   // Length, lines-written and drop counters
   localparam int CNT_W       = 32;

   // Credit FIFO geometry
   localparam int FIFO_DEPTH  = 8;
   localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);
   // One extra bit so a counter can hold FIFO_DEPTH itself
   localparam int CREDIT_W    = $clog2(FIFO_DEPTH) + 1;

   //////////////////////////////////////////////////////////////////////
   // Codes
   //////////////////////////////////////////////////////////////////////
   // Virtual channel, only VA is used
   localparam logic [1:0] VC_VA      = 2'b00;

   // Request types on Tx0 and Tx1
   localparam logic [3:0] REQ_RDLINE = 4'h1;
   localparam logic [3:0] REQ_WRLINE = 4'h2;
   // Response types on Rx0 and Rx1
   localparam logic [3:0] RSP_RD     = 4'h4;
   localparam logic [3:0] RSP_WR     = 4'h1;

   // Channel codes, also the bit positions of the trace mask
   localparam logic [1:0] CH_TX0     = 2'd0;
   localparam logic [1:0] CH_TX1     = 2'd1;
   localparam logic [1:0] CH_RX0     = 2'd2;
   localparam logic [1:0] CH_RX1     = 2'd3;

   // MMIO register indices
   localparam logic [MMIO_IDX_W-1:0] REG_SRC    = 16'd0;
   localparam logic [MMIO_IDX_W-1:0] REG_DST    = 16'd1;
   localparam logic [MMIO_IDX_W-1:0] REG_LEN    = 16'd2;
   localparam logic [MMIO_IDX_W-1:0] REG_CTRL   = 16'd3;
   localparam logic [MMIO_IDX_W-1:0] REG_STATUS = 16'd4;
   localparam logic [MMIO_IDX_W-1:0] REG_DROPS  = 16'd5;

   //////////////////////////////////////////////////////////////////////
   // Headers and records
   //////////////////////////////////////////////////////////////////////
   // Tx0 / Tx1 request header, 54 bits
   typedef struct packed {
      logic [1:0]         vc;
      logic [3:0]         reqType;
      logic [MDATA_W-1:0] mdata;
      logic [ADDR_W-1:0]  addr;
   } txHdr_t;

   // Rx0 / Rx1 response header, 22 bits
   typedef struct packed {
      logic [1:0]         vc;
      logic [3:0]         respType;
      logic [MDATA_W-1:0] mdata;
   } rxHdr_t;

   // MMIO request and read response header
   typedef struct packed {
      logic [MMIO_IDX_W-1:0] index;
      logic [TID_W-1:0]      tid;
   } mmioHdr_t;

   // Buffered read response
   typedef struct packed {
      logic [MDATA_W-1:0] mdata;
      logic [LINE_W-1:0]  data;
   } rdResp_t;

   // Trace record, addr is zero for Rx events
   typedef struct packed {
      logic [TS_W-1:0]    timeStamp;
      logic [1:0]         chan;
      logic [3:0]         kind;
      logic [MDATA_W-1:0] mdata;
      logic [ADDR_W-1:0]  addr;
   } traceRec_t;

endpackage

`default_nettype wire

/* logic/copyControl.sv */
// Copy control, MMIO register file, read issue under Tx0 credit and completion count
`timescale 1ns/1ps
`default_nettype none

module copyControl import ccipPkg::*;
#(
   parameter int TX_CREDITS = 4
)
(
   input  wire logic              clk,
   input  wire logic              rstN,
   input  wire logic              mmioWrValid,
   input  wire logic              mmioRdValid,
   input  wire mmioHdr_t          mmioHdr,
   input  wire logic [MMIO_W-1:0] mmioWrData,
   input  wire logic              tx0CreditReturn,
   input  wire logic              rx1Valid,
   input  wire logic [CNT_W-1:0]  dropCount,
   output logic                   tx0Valid,
   output txHdr_t                 tx0Hdr,
   output logic                   tx2Valid,
   output mmioHdr_t               tx2Hdr,
   output logic [MMIO_W-1:0]      tx2Data,
   output logic [ADDR_W-1:0]      dstBase,
   output logic [3:0]             traceMask
);

   logic [ADDR_W-1:0]   srcBase;
   logic [CNT_W-1:0]    lenReg;
   logic [CNT_W-1:0]    issueIdx;
   logic [CNT_W-1:0]    linesWritten;
   logic                busy;
   logic                done;
   logic [CREDIT_W-1:0] tx0Credits;
   logic [MMIO_W-1:0]   rdData;

   // Issue whenever lines remain and a credit is held
   assign tx0Valid = busy && (tx0Credits != '0);

   always_comb
   begin
      tx0Hdr.vc      = VC_VA;
      tx0Hdr.reqType = REQ_RDLINE;
      // Line index doubles as the tag
      tx0Hdr.mdata   = issueIdx[MDATA_W-1:0];
      tx0Hdr.addr    = srcBase + ADDR_W'(issueIdx);
   end

   //////////////////////////////////////////////////////////////////////
   // Register file and issue state
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         srcBase      <= '0;
         dstBase      <= '0;
         lenReg       <= '0;
         traceMask    <= '0;
         busy         <= 1'b0;
         done         <= 1'b0;
         issueIdx     <= '0;
         linesWritten <= '0;
      end
      else
      begin
         // Step through the block one read at a time
         if (tx0Valid)
         begin
            issueIdx <= issueIdx + 1'b1;
            if (issueIdx == lenReg - 1'b1)
               busy <= 1'b0;
         end
         // Write responses, done on the last one
         if (rx1Valid)
         begin
            linesWritten <= linesWritten + 1'b1;
            if (linesWritten == lenReg - 1'b1)
               done <= 1'b1;
         end
         if (mmioWrValid)
         begin
            case (mmioHdr.index)
               REG_SRC: srcBase <= mmioWrData[ADDR_W-1:0];
               REG_DST: dstBase <= mmioWrData[ADDR_W-1:0];
               REG_LEN: lenReg  <= mmioWrData[CNT_W-1:0];
               REG_CTRL:
               begin
                  traceMask <= mmioWrData[7:4];
                  // Start only with a nonzero length
                  if (mmioWrData[0] && (lenReg != '0))
                  begin
                     busy         <= 1'b1;
                     done         <= 1'b0;
                     issueIdx     <= '0;
                     linesWritten <= '0;
                  end
               end
               default: ;
            endcase
         end
      end
   end

   // Tx0 credits, one per beat out, one per return pulse
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
         tx0Credits <= CREDIT_W'(TX_CREDITS);
      else
         tx0Credits <= tx0Credits - CREDIT_W'(tx0Valid) + CREDIT_W'(tx0CreditReturn);
   end

   //////////////////////////////////////////////////////////////////////
   // MMIO read path
   //////////////////////////////////////////////////////////////////////
   always_comb
   begin
      case (mmioHdr.index)
         REG_SRC:    rdData = MMIO_W'(srcBase);
         REG_DST:    rdData = MMIO_W'(dstBase);
         REG_LEN:    rdData = MMIO_W'(lenReg);
         // Bit 0 reads back as busy
         REG_CTRL:   rdData = {56'd0, traceMask, 3'd0, busy};
         REG_STATUS: rdData = {done, 31'd0, linesWritten};
         REG_DROPS:  rdData = MMIO_W'(dropCount);
         default:    rdData = '0;
      endcase
   end

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
         tx2Valid <= 1'b0;
      else
         tx2Valid <= mmioRdValid;
   end

   // Answer one cycle later with the tid echoed
   always_ff @(posedge clk)
   begin
      if (mmioRdValid)
      begin
         tx2Hdr  <= mmioHdr;
         tx2Data <= rdData;
      end
   end

endmodule

`default_nettype wire

/* logic/copyEngineTop.sv */
// Copy engine top, control, write path, tracer and the two credit FIFOs
`timescale 1ns/1ps
`default_nettype none

module copyEngineTop import ccipPkg::*;
#(
   parameter int TX_CREDITS = 4
)
(
   input  wire logic              clk,
   input  wire logic              rstN,
   // MMIO requests and read responses
   input  wire logic              mmioWrValid,
   input  wire logic              mmioRdValid,
   input  wire mmioHdr_t          mmioHdr,
   input  wire logic [MMIO_W-1:0] mmioWrData,
   output logic                   tx2Valid,
   output mmioHdr_t               tx2Hdr,
   output logic [MMIO_W-1:0]      tx2Data,
   // Memory request channels
   output logic                   tx0Valid,
   output txHdr_t                 tx0Hdr,
   input  wire logic              tx0CreditReturn,
   output logic                   tx1Valid,
   output txHdr_t                 tx1Hdr,
   output logic [LINE_W-1:0]      tx1Data,
   input  wire logic              tx1CreditReturn,
   // Memory response channels
   input  wire logic              rx0Valid,
   input  wire rxHdr_t            rx0Hdr,
   input  wire logic [LINE_W-1:0] rx0Data,
   input  wire logic              rx1Valid,
   input  wire rxHdr_t            rx1Hdr,
   // Trace port
   output logic                   traceValid,
   output traceRec_t              traceRec,
   input  wire logic              traceCreditReturn
);

   logic [ADDR_W-1:0] dstBase;
   logic [3:0]        traceMask;
   logic [CNT_W-1:0]  dropCount;
   rdResp_t           rspIn;
   rdResp_t           rspOut;
   logic              rspReady;
   logic              rspPop;
   traceRec_t         rec;
   logic              recPush;
   logic              traceFull;
   logic              traceNotEmpty;

   // Read response payload for the buffer
   assign rspIn.mdata = rx0Hdr.mdata;
   assign rspIn.data  = rx0Data;

   //////////////////////////////////////////////////////////////////////
   // Instances
   //////////////////////////////////////////////////////////////////////
   copyControl #(.TX_CREDITS(TX_CREDITS)) copyControl_inst (
      .clk(clk), .rstN(rstN),
      .mmioWrValid(mmioWrValid), .mmioRdValid(mmioRdValid),
      .mmioHdr(mmioHdr), .mmioWrData(mmioWrData),
      .tx0CreditReturn(tx0CreditReturn), .rx1Valid(rx1Valid),
      .dropCount(dropCount),
      .tx0Valid(tx0Valid), .tx0Hdr(tx0Hdr),
      .tx2Valid(tx2Valid), .tx2Hdr(tx2Hdr), .tx2Data(tx2Data),
      .dstBase(dstBase), .traceMask(traceMask)
   );

   // Never overflows, Tx0 credits stay within FIFO_DEPTH
   creditFifo #(.payload_t(rdResp_t)) rspFifo_inst (
      .clk(clk), .rstN(rstN),
      .push(rx0Valid), .pushData(rspIn),
      .pop(rspPop), .popData(rspOut),
      .notEmpty(rspReady), .full()
   );

   lineWriter #(.TX_CREDITS(TX_CREDITS)) lineWriter_inst (
      .clk(clk), .rstN(rstN),
      .respReady(rspReady), .resp(rspOut), .dstBase(dstBase),
      .tx1CreditReturn(tx1CreditReturn), .respPop(rspPop),
      .tx1Valid(tx1Valid), .tx1Hdr(tx1Hdr), .tx1Data(tx1Data)
   );

   txnTracer txnTracer_inst (
      .clk(clk), .rstN(rstN), .traceMask(traceMask),
      .tx0Valid(tx0Valid), .tx1Valid(tx1Valid),
      .rx0Valid(rx0Valid), .rx1Valid(rx1Valid),
      .tx0Hdr(tx0Hdr), .tx1Hdr(tx1Hdr), .rx0Hdr(rx0Hdr), .rx1Hdr(rx1Hdr),
      .fifoFull(traceFull), .fifoNotEmpty(traceNotEmpty),
      .traceCreditReturn(traceCreditReturn),
      .recPush(recPush), .rec(rec),
      .fifoPop(traceValid), .dropCount(dropCount)
   );

   // Each pop is one beat on the trace port
   creditFifo #(.payload_t(traceRec_t)) traceFifo_inst (
      .clk(clk), .rstN(rstN),
      .push(recPush), .pushData(rec),
      .pop(traceValid), .popData(traceRec),
      .notEmpty(traceNotEmpty), .full(traceFull)
   );

endmodule

`default_nettype wire

/* logic/creditFifo.sv */
// Circular buffer FIFO with occupancy count, generic over its payload type
`timescale 1ns/1ps
`default_nettype none

module creditFifo import ccipPkg::*;
#(
   parameter type payload_t = rdResp_t
)
(
   input  wire logic     clk,
   input  wire logic     rstN,
   input  wire logic     push,
   input  wire payload_t pushData,
   input  wire logic     pop,
   output payload_t      popData,
   output logic          notEmpty,
   output logic          full
);

   payload_t              mem [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] wrPtr;
   logic [FIFO_PTR_W-1:0] rdPtr;
   logic [CREDIT_W-1:0]   count;
   logic                  doPush;
   logic                  doPop;

   // Ignore push when full and pop when empty
   assign doPush   = push && !full;
   assign doPop    = pop && notEmpty;
   assign notEmpty = (count != '0);
   assign full     = (count == CREDIT_W'(FIFO_DEPTH));
   // Head word visible without a read cycle
   assign popData  = mem[rdPtr];

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end
      else
      begin
         if (doPush)
            wrPtr <= wrPtr + 1'b1;
         if (doPop)
            rdPtr <= rdPtr + 1'b1;
         count <= count + CREDIT_W'(doPush) - CREDIT_W'(doPop);
      end
   end

   always_ff @(posedge clk)
   begin
      if (doPush)
         mem[wrPtr] <= pushData;
   end

endmodule

`default_nettype wire

/* logic/lineWriter.sv */
// Line writer, turns buffered read responses into Tx1 write requests under credit
`timescale 1ns/1ps
`default_nettype none

module lineWriter import ccipPkg::*;
#(
   parameter int TX_CREDITS = 4
)
(
   input  wire logic              clk,
   input  wire logic              rstN,
   input  wire logic              respReady,
   input  wire rdResp_t           resp,
   input  wire logic [ADDR_W-1:0] dstBase,
   input  wire logic              tx1CreditReturn,
   output logic                   respPop,
   output logic                   tx1Valid,
   output txHdr_t                 tx1Hdr,
   output logic [LINE_W-1:0]      tx1Data
);

   logic [CREDIT_W-1:0] tx1Credits;

   // Credit is spent at pop, the beat follows one cycle later
   assign respPop = respReady && (tx1Credits != '0);

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         tx1Credits <= CREDIT_W'(TX_CREDITS);
         tx1Valid   <= 1'b0;
      end
      else
      begin
         tx1Credits <= tx1Credits - CREDIT_W'(respPop) + CREDIT_W'(tx1CreditReturn);
         tx1Valid   <= respPop;
      end
   end

   // Write header rebuilt from the line index in mdata
   always_ff @(posedge clk)
   begin
      if (respPop)
      begin
         tx1Hdr.vc      <= VC_VA;
         tx1Hdr.reqType <= REQ_WRLINE;
         tx1Hdr.mdata   <= resp.mdata;
         tx1Hdr.addr    <= dstBase + ADDR_W'(resp.mdata);
         tx1Data        <= resp.data;
      end
   end

endmodule

`default_nettype wire

/* logic/txnTracer.sv */
// Transaction tracer, time-stamps masked channel events into trace records
`timescale 1ns/1ps
`default_nettype none

module txnTracer import ccipPkg::*;
(
   input  wire logic             clk,
   input  wire logic             rstN,
   input  wire logic [3:0]       traceMask,
   input  wire logic             tx0Valid,
   input  wire logic             tx1Valid,
   input  wire logic             rx0Valid,
   input  wire logic             rx1Valid,
   input  wire txHdr_t           tx0Hdr,
   input  wire txHdr_t           tx1Hdr,
   input  wire rxHdr_t           rx0Hdr,
   input  wire rxHdr_t           rx1Hdr,
   input  wire logic             fifoFull,
   input  wire logic             fifoNotEmpty,
   input  wire logic             traceCreditReturn,
   output logic                  recPush,
   output traceRec_t             rec,
   output logic                  fifoPop,
   output logic [CNT_W-1:0]      dropCount
);

   logic [TS_W-1:0]     timeStamp;
   logic [3:0]          evt;
   logic [2:0]          evtCount;
   logic [CREDIT_W-1:0] traceCredits;

   // Enabled events, indexed by channel code
   assign evt      = {rx1Valid, rx0Valid, tx1Valid, tx0Valid} & traceMask;
   assign evtCount = 3'(evt[0]) + 3'(evt[1]) + 3'(evt[2]) + 3'(evt[3]);
   assign recPush  = (evt != '0) && !fifoFull;

   //////////////////////////////////////////////////////////////////////
   // Record build, lowest channel code wins
   //////////////////////////////////////////////////////////////////////
   always_comb
   begin
      rec.timeStamp = timeStamp;
      rec.chan      = CH_RX1;
      rec.kind      = rx1Hdr.respType;
      rec.mdata     = rx1Hdr.mdata;
      rec.addr      = '0;
      if (evt[CH_TX0])
      begin
         rec.chan  = CH_TX0;
         rec.kind  = tx0Hdr.reqType;
         rec.mdata = tx0Hdr.mdata;
         rec.addr  = tx0Hdr.addr;
      end
      else if (evt[CH_TX1])
      begin
         rec.chan  = CH_TX1;
         rec.kind  = tx1Hdr.reqType;
         rec.mdata = tx1Hdr.mdata;
         rec.addr  = tx1Hdr.addr;
      end
      else if (evt[CH_RX0])
      begin
         rec.chan  = CH_RX0;
         rec.kind  = rx0Hdr.respType;
         rec.mdata = rx0Hdr.mdata;
      end
   end

   // Drain toward the trace port while the consumer has room
   assign fifoPop = fifoNotEmpty && (traceCredits != '0);

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         timeStamp    <= '0;
         dropCount    <= '0;
         traceCredits <= CREDIT_W'(FIFO_DEPTH);
      end
      else
      begin
         timeStamp    <= timeStamp + 1'b1;
         // Every enabled event not recorded is a drop
         dropCount    <= dropCount + CNT_W'(evtCount) - CNT_W'(recPush);
         traceCredits <= traceCredits - CREDIT_W'(fifoPop) + CREDIT_W'(traceCreditReturn);
      end
   end

endmodule

`default_nettype wire

/* tb/copyEngineTb.sv */
// Testbench for the copy engine with MMIO setup, two copies and trace and credit checks
`timescale 1ns/1ps
`default_nettype none

module copyEngineTb import ccipPkg::*;
();

   localparam int TX_CREDITS  = 4;
   localparam int RUN_LEN     = 20;
   localparam int TOTAL_LINES = 2 * RUN_LEN;

   logic              clk = 1'b0;
   logic              rstN = 1'b0;
   logic              mmioWrValid = 1'b0;
   logic              mmioRdValid = 1'b0;
   mmioHdr_t          mmioHdr = '0;
   logic [MMIO_W-1:0] mmioWrData = '0;
   logic              tx2Valid;
   mmioHdr_t          tx2Hdr;
   logic [MMIO_W-1:0] tx2Data;
   logic              tx0Valid;
   txHdr_t            tx0Hdr;
   logic              tx0CreditReturn;
   logic              tx1Valid;
   txHdr_t            tx1Hdr;
   logic [LINE_W-1:0] tx1Data;
   logic              tx1CreditReturn;
   logic              rx0Valid;
   rxHdr_t            rx0Hdr;
   logic [LINE_W-1:0] rx0Data;
   logic              rx1Valid;
   rxHdr_t            rx1Hdr;
   logic              traceValid;
   traceRec_t         traceRec;
   logic              traceCreditReturn = 1'b0;

   // Scoreboard state
   int                checks = 0;
   int                errors = 0;
   logic              creditHold = 1'b0;
   logic              traceHold = 1'b0;
   logic [3:0]        traceMaskTb = '0;
   logic [ADDR_W-1:0] curSrc = '0;
   logic [ADDR_W-1:0] curDst = '0;
   int                curLen = 0;
   int                rdIdx = 0;
   int                rx1Count = 0;
   int                delivered = 0;
   int                tx0Out = 0;
   int                tx1Out = 0;
   int                traceOwed = 0;
   logic [TS_W-1:0]   ts = '0;
   logic              rdPend = 1'b0;
   mmioHdr_t          expRdHdr = '0;
   logic [TID_W-1:0]  nextTid = '0;
   logic              seen [64];
   traceRec_t         traceQ[$];

   always #2 clk = ~clk;

   copyEngineTop #(.TX_CREDITS(TX_CREDITS)) copyEngineTop_inst (
      .clk(clk), .rstN(rstN),
      .mmioWrValid(mmioWrValid), .mmioRdValid(mmioRdValid),
      .mmioHdr(mmioHdr), .mmioWrData(mmioWrData),
      .tx2Valid(tx2Valid), .tx2Hdr(tx2Hdr), .tx2Data(tx2Data),
      .tx0Valid(tx0Valid), .tx0Hdr(tx0Hdr), .tx0CreditReturn(tx0CreditReturn),
      .tx1Valid(tx1Valid), .tx1Hdr(tx1Hdr), .tx1Data(tx1Data),
      .tx1CreditReturn(tx1CreditReturn),
      .rx0Valid(rx0Valid), .rx0Hdr(rx0Hdr), .rx0Data(rx0Data),
      .rx1Valid(rx1Valid), .rx1Hdr(rx1Hdr),
      .traceValid(traceValid), .traceRec(traceRec),
      .traceCreditReturn(traceCreditReturn)
   );

   hostMemModel hostMemModel_inst (
      .clk(clk), .rstN(rstN), .hold(creditHold),
      .tx0Valid(tx0Valid), .tx0Hdr(tx0Hdr),
      .tx1Valid(tx1Valid), .tx1Hdr(tx1Hdr),
      .tx0CreditReturn(tx0CreditReturn), .tx1CreditReturn(tx1CreditReturn),
      .rx0Valid(rx0Valid), .rx0Hdr(rx0Hdr), .rx0Data(rx0Data),
      .rx1Valid(rx1Valid), .rx1Hdr(rx1Hdr)
   );

   //////////////////////////////////////////////////////////////////////
   // Reference model and check helpers
   //////////////////////////////////////////////////////////////////////
   // Expected memory contents per line address
   function automatic logic [LINE_W-1:0] memWord(input logic [ADDR_W-1:0] addr);
      return {~addr, addr} ^ 64'hC3A5_0F96_5A3C_E187;
   endfunction

   function automatic traceRec_t expectRecord(input logic [TS_W-1:0] stamp,
         input logic [1:0] chan, input logic [3:0] kind, input int idx,
         input logic [ADDR_W-1:0] addr);
      return '{timeStamp: stamp, chan: chan, kind: kind,
               mdata: MDATA_W'(idx), addr: addr};
   endfunction

   task automatic checkValue(input string name, input logic [127:0] expVal,
         input logic [127:0] actVal);
      checks++;
      assert (expVal === actVal)
      else
      begin
         $display("FAIL t=%0t %s expected %0h actual %0h", $time, name, expVal, actVal);
         errors++;
      end
   endtask

   task automatic checkTrue(input logic cond, input string msg);
      checks++;
      assert (cond)
      else
      begin
         $display("ERROR t=%0t %s", $time, msg);
         errors++;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Comparison process sampling every beat at the rising edge
   //////////////////////////////////////////////////////////////////////
   always @(posedge clk)
   begin
      traceRec_t expRec;
      int        idx;
      rdPend   <= mmioRdValid;
      expRdHdr <= mmioHdr;
      if (!rstN)
         ts <= '0;
      else
      begin
         ts <= ts + 1'b1;
         // MMIO answer exactly one cycle after the request
         checkValue("tx2Valid", rdPend, tx2Valid);
         if (tx2Valid && rdPend)
            checkValue("tx2Hdr", expRdHdr, tx2Hdr);
         // Trace port first since records always trail their events
         if (traceValid)
         begin
            checkTrue(traceQ.size() != 0, "Trace record delivered with no pending event");
            if (traceQ.size() != 0)
            begin
               expRec = traceQ.pop_front();
               checkValue("traceRec", expRec, traceRec);
            end
            delivered++;
         end
         // Reads issued in line order
         if (tx0Valid)
         begin
            checkValue("tx0Hdr.vc", VC_VA, tx0Hdr.vc);
            checkValue("tx0Hdr.reqType", REQ_RDLINE, tx0Hdr.reqType);
            checkValue("tx0Hdr.mdata", MDATA_W'(rdIdx), tx0Hdr.mdata);
            checkValue("tx0Hdr.addr", curSrc + rdIdx, tx0Hdr.addr);
            if (traceMaskTb[CH_TX0])
               traceQ.push_back(expectRecord(ts, CH_TX0, REQ_RDLINE, rdIdx, curSrc + rdIdx));
            rdIdx++;
         end
         // Writes in any order with each line once
         if (tx1Valid)
         begin
            idx = int'(tx1Hdr.mdata);
            checkTrue(idx < curLen && !seen[idx % 64], "Tx1 line index out of range or repeated");
            seen[idx % 64] = 1'b1;
            checkValue("tx1Hdr.vc", VC_VA, tx1Hdr.vc);
            checkValue("tx1Hdr.reqType", REQ_WRLINE, tx1Hdr.reqType);
            checkValue("tx1Hdr.addr", curDst + idx, tx1Hdr.addr);
            checkValue("tx1Data", memWord(curSrc + idx), tx1Data);
            if (traceMaskTb[CH_TX1])
               traceQ.push_back(expectRecord(ts, CH_TX1, REQ_WRLINE, idx, curDst + idx));
         end
         if (rx1Valid)
            rx1Count++;
         // Outstanding beats never beyond the credit limit
         tx0Out = tx0Out + int'(tx0Valid) - int'(tx0CreditReturn);
         tx1Out = tx1Out + int'(tx1Valid) - int'(tx1CreditReturn);
         checkTrue(tx0Out <= TX_CREDITS, "Tx0 sent more beats than credits allow");
         checkTrue(tx1Out <= TX_CREDITS, "Tx1 sent more beats than credits allow");
      end
   end

   // Trace consumer returns one credit per record unless held
   always @(posedge clk)
   begin
      if (traceValid)
         traceOwed++;
      if (rstN && !traceHold && traceOwed > 0)
      begin
         traceCreditReturn <= 1'b1;
         traceOwed--;
      end
      else
         traceCreditReturn <= 1'b0;
   end

   //////////////////////////////////////////////////////////////////////
   // MMIO tasks
   //////////////////////////////////////////////////////////////////////
   task automatic mmioWrite(input logic [MMIO_IDX_W-1:0] index, input logic [MMIO_W-1:0] data);
      @(posedge clk);
      mmioWrValid <= 1'b1;
      mmioHdr     <= '{index: index, tid: nextTid};
      mmioWrData  <= data;
      @(posedge clk);
      mmioWrValid <= 1'b0;
   endtask

   task automatic mmioRead(input logic [MMIO_IDX_W-1:0] index, output logic [MMIO_W-1:0] data);
      int wait4;
      data = '0;
      nextTid++;
      @(posedge clk);
      mmioRdValid <= 1'b1;
      mmioHdr     <= '{index: index, tid: nextTid};
      @(posedge clk);
      mmioRdValid <= 1'b0;
      for (wait4 = 0; wait4 < 8; wait4++)
      begin
         @(posedge clk);
         if (tx2Valid)
         begin
            data = tx2Data;
            return;
         end
      end
      checkTrue(1'b0, "No MMIO read response");
   endtask

   // Poll status until done
   // Done must not precede the last write response
   task automatic waitDone();
      logic [MMIO_W-1:0] status;
      do
      begin
         mmioRead(REG_STATUS, status);
         checkTrue(!status[63] || rx1Count == curLen, "Done set before the last write response");
      end
      while (!status[63]);
      checkValue("status.linesWritten", curLen, status[31:0]);
   endtask

   task automatic waitTraceIdle();
      int idle;
      idle = 0;
      while (idle < 20)
      begin
         @(posedge clk);
         if (traceValid)
            idle = 0;
         else
            idle++;
      end
   endtask

   task automatic startRun(input logic [ADDR_W-1:0] src, input logic [ADDR_W-1:0] dst,
         input logic [3:0] mask);
      logic [MMIO_W-1:0] status;
      curSrc      = src;
      curDst      = dst;
      curLen      = RUN_LEN;
      traceMaskTb = mask;
      rdIdx       = 0;
      rx1Count    = 0;
      delivered   = 0;
      foreach (seen[i])
         seen[i] = 1'b0;
      mmioWrite(REG_SRC, MMIO_W'(src));
      mmioWrite(REG_DST, MMIO_W'(dst));
      mmioWrite(REG_LEN, MMIO_W'(RUN_LEN));
      mmioWrite(REG_CTRL, {56'd0, mask, 4'h1});
      mmioRead(REG_STATUS, status);
      checkValue("status.done", 1'b0, status[63]);
   endtask

   task automatic checkAllWritten();
      int i;
      for (i = 0; i < curLen; i++)
         checkTrue(seen[i], "A line of the copy was never written");
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////////////////////////
   initial
   begin
      logic [MMIO_W-1:0] rdVal;
      logic [MMIO_W-1:0] dropsBase;
      int                drops;
      repeat (10) @(posedge clk);
      rstN <= 1'b1;
      repeat (2) @(posedge clk);

      // Register readback
      mmioWrite(REG_SRC, 64'h0000_1234);
      mmioWrite(REG_DST, 64'h0004_5678);
      mmioWrite(REG_LEN, 64'd7);
      mmioRead(REG_SRC, rdVal);
      checkValue("REG_SRC", 64'h0000_1234, rdVal);
      mmioRead(REG_DST, rdVal);
      checkValue("REG_DST", 64'h0004_5678, rdVal);
      mmioRead(REG_LEN, rdVal);
      checkValue("REG_LEN", 64'd7, rdVal);

      // Run A traces Tx0 while the host withholds credits for a while
      creditHold <= 1'b1;
      startRun(32'h0000_1000, 32'h0004_0000, 4'b0001);
      repeat (80) @(posedge clk);
      creditHold <= 1'b0;
      waitDone();
      waitTraceIdle();
      checkAllWritten();
      checkValue("pending trace records", 0, traceQ.size());
      mmioRead(REG_DROPS, dropsBase);

      // Run B traces Tx1 with the trace consumer stalled
      traceHold <= 1'b1;
      startRun(32'h0000_2000, 32'h0008_0000, 4'b0010);
      waitDone();
      checkAllWritten();
      traceHold <= 1'b0;
      waitTraceIdle();
      mmioRead(REG_DROPS, rdVal);
      drops = int'(rdVal - dropsBase);
      checkValue("delivered plus drops", RUN_LEN, delivered + drops);
      checkValue("undelivered trace events", drops, traceQ.size());

      $display("Checks: %0d  Errors: %0d", checks, errors);
      if (errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

   // Watchdog scaled to the number of copied lines
   initial
   begin
      repeat (TOTAL_LINES * 200 + 2000) @(posedge clk);
      $display("Watchdog expired before the copies completed");
      $display("Checks: %0d  Errors: %0d", checks, errors + 1);
      $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

/* tb/hostMemModel.sv */
// Host memory model that answers reads and writes after random delays and returns credits
`timescale 1ns/1ps
`default_nettype none

module hostMemModel import ccipPkg::*;
(
   input  wire logic              clk,
   input  wire logic              rstN,
   input  wire logic              hold,
   input  wire logic              tx0Valid,
   input  wire txHdr_t            tx0Hdr,
   input  wire logic              tx1Valid,
   input  wire txHdr_t            tx1Hdr,
   output logic                   tx0CreditReturn,
   output logic                   tx1CreditReturn,
   output logic                   rx0Valid,
   output rxHdr_t                 rx0Hdr,
   output logic [LINE_W-1:0]      rx0Data,
   output logic                   rx1Valid,
   output rxHdr_t                 rx1Hdr
);

   int unsigned        lcgState = 2;
   int                 cycle = 0;
   // Pending read responses
   int                 rdDue[$];
   logic [MDATA_W-1:0] rdTag[$];
   logic [ADDR_W-1:0]  rdAddr[$];
   // Pending write responses
   int                 wrDue[$];
   logic [MDATA_W-1:0] wrTag[$];
   // Credit return times
   int                 c0Due[$];
   int                 c1Due[$];

   // Linear congruential generator with 15 bits out
   function automatic int unsigned nextRand();
      lcgState = lcgState * 32'd1103515245 + 32'd12345;
      return (lcgState >> 16) & 32'h7fff;
   endfunction

   // Memory contents where every address bit takes part
   function automatic logic [LINE_W-1:0] lineData(input logic [ADDR_W-1:0] addr);
      return {~addr, addr} ^ 64'hC3A5_0F96_5A3C_E187;
   endfunction

   // Quiet response and credit channels from time zero
   initial
   begin
      tx0CreditReturn = 1'b0;
      tx1CreditReturn = 1'b0;
      rx0Valid        = 1'b0;
      rx0Hdr          = '0;
      rx0Data         = '0;
      rx1Valid        = 1'b0;
      rx1Hdr          = '0;
   end

   always @(posedge clk)
   begin
      int  i;
      logic sent;
      if (!rstN)
      begin
         tx0CreditReturn <= 1'b0;
         tx1CreditReturn <= 1'b0;
         rx0Valid        <= 1'b0;
         rx1Valid        <= 1'b0;
      end
      else
      begin
         cycle++;
         // Accept requests with a random latency per line
         if (tx0Valid)
         begin
            rdDue.push_back(cycle + 2 + int'(nextRand() % 12));
            rdTag.push_back(tx0Hdr.mdata);
            rdAddr.push_back(tx0Hdr.addr);
         end
         if (tx1Valid)
         begin
            wrDue.push_back(cycle + 1 + int'(nextRand() % 8));
            wrTag.push_back(tx1Hdr.mdata);
            // Read slot counts as free once its line is written
            c0Due.push_back(cycle + 1 + int'(nextRand() % 6));
            c1Due.push_back(cycle + 1 + int'(nextRand() % 6));
         end
         // At most one read response per cycle taking the first one due
         rx0Valid <= 1'b0;
         sent = 1'b0;
         for (i = 0; i < rdDue.size() && !sent; i++)
         begin
            if (rdDue[i] <= cycle)
            begin
               rx0Valid <= 1'b1;
               rx0Hdr   <= '{vc: VC_VA, respType: RSP_RD, mdata: rdTag[i]};
               rx0Data  <= lineData(rdAddr[i]);
               rdDue.delete(i);
               rdTag.delete(i);
               rdAddr.delete(i);
               sent = 1'b1;
            end
         end
         // At most one write response
         rx1Valid <= 1'b0;
         sent = 1'b0;
         for (i = 0; i < wrDue.size() && !sent; i++)
         begin
            if (wrDue[i] <= cycle)
            begin
               rx1Valid <= 1'b1;
               rx1Hdr   <= '{vc: VC_VA, respType: RSP_WR, mdata: wrTag[i]};
               wrDue.delete(i);
               wrTag.delete(i);
               sent = 1'b1;
            end
         end
         // Credit pulses held back while hold is up
         tx0CreditReturn <= 1'b0;
         if (!hold && c0Due.size() != 0 && c0Due[0] <= cycle)
         begin
            tx0CreditReturn <= 1'b1;
            void'(c0Due.pop_front());
         end
         tx1CreditReturn <= 1'b0;
         if (!hold && c1Due.size() != 0 && c1Due[0] <= cycle)
         begin
            tx1CreditReturn <= 1'b1;
            void'(c1Due.pop_front());
         end
      end
   end

endmodule

`default_nettype wire
